//--- mcntrl_ps_pio.f
+incdir+rtl
rtl/ps_pio_cmd_pkg.sv
rtl/ps_pio_buf_pkg.sv
rtl/cmd_deser.sv
rtl/status_generate.sv
rtl/cmd_fifo.sv
rtl/ps_pio_control.sv
rtl/page_buffer.sv
rtl/mcntrl_ps_pio.sv
testbench/mcntrl_ps_pio_asserts.sv
testbench/tb_mcntrl_ps_pio.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, then looks for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_mcntrl_ps_pio \
    -f mcntrl_ps_pio.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_mcntrl_ps_pio > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

//--- testbench/tb_mcntrl_ps_pio.sv
/* directed tests of the ps pio channel, host and memory sides on one clock
   port rst is the clock and mclk the active-low reset, as on the DUT */
`timescale 1ns/1ns
`default_nettype none
`include "ps_pio_consts.svh"

module tb_mcntrl_ps_pio;
    localparam int CLK_PERIOD  = 10;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;

    logic        rst;              // clock
    logic        mclk;             // reset, active low
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic        status_start;
    logic        port0_re;
    logic        port0_regen;
    logic [9:0]  port0_addr;
    logic [31:0] port0_data;
    logic        port1_we;
    logic [9:0]  port1_addr;
    logic [31:0] port1_data;
    logic        want_rq0;
    logic        need_rq0;
    logic        channel_pgm_en0;
    logic [9:0]  seq_data0;
    logic        seq_set0;
    logic        seq_done0;
    logic        buf_wr_chn0;
    logic        buf_wpage_nxt_chn0;
    logic [63:0] buf_wdata_chn0;
    logic        want_rq1;
    logic        need_rq1;
    logic        channel_pgm_en1;
    logic        seq_done1;
    logic        rpage_nxt_chn1;
    logic        buf_rd_chn1;
    logic [63:0] buf_rdata_chn1;

    logic [31:0] lcg_state;
    int          errors;

    mcntrl_ps_pio DUT (.*);

    initial begin
        rst = 1'b0;
        forever #(CLK_PERIOD / 2) rst = ~rst;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog");
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // {want0, need0, want1, need1} expected for a command word
    function automatic logic [3:0] rq_bits(input logic [31:0] cmd);
        return {!cmd[13], !cmd[13] && cmd[12], cmd[13], cmd[13] && cmd[12]};
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_now(input string what);
        errors++;
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // AL AH D0 D1 D2 D3, stb with AL; returns on the edge after D3
    task automatic send_frame(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] frame;
        frame = {data, addr};
        for (int k = 0; k < `CMD_NUM_BYTES; k++) begin
            @(posedge rst);
            cmd_ad  <= frame[8*k +: 8];
            cmd_stb <= (k == 0);
        end
        @(posedge rst);
        cmd_ad <= 8'h00;
    endtask

    task automatic write_reg(input logic [4:0] sub, input logic [31:0] data);
        send_frame(`PS_ADDR | {11'd0, sub}, data);
    endtask

    task automatic expect_no_request(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge rst);
            check(name, 64'd0, {62'd0, want_rq0, want_rq1});
        end
    endtask

    task automatic wait_request(input string name);
        int n;
        n = 0;
        @(negedge rst);
        while (!(want_rq0 || want_rq1) && n < 20) begin
            @(negedge rst);
            n++;
        end
        if (!(want_rq0 || want_rq1))
            fail_now({"no memory request raised in test ", name});
    endtask

    task automatic wait_status_rq(input string name);
        int n;
        n = 0;
        @(negedge rst);
        while (!status_rq && n < 20) begin
            @(negedge rst);
            n++;
        end
        if (!status_rq)
            fail_now({"status request never raised in test ", name});
    endtask

    // grant one cycle, seq_set and seq_data expected on the next
    task automatic grant_and_check(input string name, input logic [31:0] cmd);
        @(posedge rst);
        if (cmd[13])
            channel_pgm_en1 <= 1'b1;
        else
            channel_pgm_en0 <= 1'b1;
        @(posedge rst);
        channel_pgm_en0 <= 1'b0;
        channel_pgm_en1 <= 1'b0;
        @(negedge rst);
        check(name, 64'd1, {63'd0, seq_set0});
        check(name, {54'd0, cmd[9:0]}, {54'd0, seq_data0});
        check(name, 64'd0, {62'd0, want_rq0, want_rq1});   // requests dropped
    endtask

    task automatic finish_seq(input logic chn);
        @(posedge rst);
        if (chn)
            seq_done1 <= 1'b1;
        else
            seq_done0 <= 1'b1;
        @(posedge rst);
        seq_done0 <= 1'b0;
        seq_done1 <= 1'b0;
    endtask

    // single-mode packet, address byte then seq and payload after start
    task automatic read_status(input string name, input logic [5:0] seq, input logic [1:0] exp);
        write_reg(`PS_STATUS_CNTRL, {24'd0, 2'b01, seq});
        wait_status_rq(name);
        check(name, {56'd0, `PS_STATUS_REG_ADDR}, {56'd0, status_ad});
        repeat (2) begin
            @(negedge rst);
            check(name, 64'd1, {63'd0, status_rq});   // holds until start
        end
        @(posedge rst);
        status_start <= 1'b1;
        @(posedge rst);
        status_start <= 1'b0;
        @(negedge rst);
        check(name, {56'd0, seq, exp}, {56'd0, status_ad});
        check(name, 64'd0, {63'd0, status_rq});
    endtask

    task automatic window_and_enable();
        logic [31:0] cmd;
        cmd = {18'd0, 1'b0, 1'b1, 2'd1, 10'h2a5};    // chn0, need, page 1
        check("reset state", 64'd0, {59'd0, want_rq0, need_rq0, want_rq1, need_rq1, seq_set0});
        check("reset state", 64'd0, {63'd0, status_rq});
        write_reg(`PS_EN_RST, 32'd3);
        send_frame(16'h141, cmd);                     // above the window
        expect_no_request("address window", 6);
        write_reg(`PS_EN_RST, 32'd1);                 // out of reset, requests off
        write_reg(`PS_CMD, cmd);
        expect_no_request("enable bit", 6);
        write_reg(`PS_EN_RST, 32'd3);
        repeat (2) @(negedge rst);
        check("enable bit", 64'd0, {62'd0, want_rq0, want_rq1});   // start condition cycle
        @(negedge rst);
        check("request", {60'd0, rq_bits(cmd)}, {60'd0, want_rq0, need_rq0, want_rq1, need_rq1});
        grant_and_check("request", cmd);
        finish_seq(cmd[13]);
    endtask

    task automatic handoff_order();
        logic [31:0] cmds [3];
        logic [31:0] r;
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            cmds[i] = {18'd0, r[13:0]};
            write_reg(`PS_CMD, cmds[i]);
        end
        for (int i = 0; i < 3; i++) begin
            wait_request("handoff");
            check("handoff", {60'd0, rq_bits(cmds[i])},
                  {60'd0, want_rq0, need_rq0, want_rq1, need_rq1});
            grant_and_check("handoff", cmds[i]);
            expect_no_request("handoff busy", 5);     // held until seq_done
            finish_seq(cmds[i][13]);
        end
    endtask

    task automatic read_buffer();
        logic [31:0] cmd;
        logic [31:0] r;
        logic [63:0] words [8];
        logic [9:0]  base;
        r = next_rand();
        cmd = {18'd0, 1'b0, r[12:0]};                 // read buffer command
        base = {cmd[11:10], 8'd0};
        write_reg(`PS_CMD, cmd);
        wait_request("read buffer");
        grant_and_check("read buffer", cmd);
        repeat (2) @(posedge rst);                    // page set reaches the buffer
        for (int i = 0; i < 8; i++) begin
            words[i][63:32] = next_rand();
            words[i][31:0]  = next_rand();
            @(posedge rst);
            buf_wr_chn0    <= 1'b1;
            buf_wdata_chn0 <= words[i];
        end
        @(posedge rst);
        buf_wr_chn0 <= 1'b0;
        finish_seq(1'b0);
        for (int i = 0; i < 8; i++) begin
            for (int h = 0; h < 2; h++) begin
                @(posedge rst);
                port0_re   <= 1'b1;
                port0_addr <= base + 10'(2 * i + h);  // low half even, high half odd
                @(posedge rst);
                port0_re    <= 1'b0;
                port0_regen <= 1'b1;
                @(posedge rst);
                port0_regen <= 1'b0;
                @(negedge rst);
                check("read buffer", {32'd0, words[i][32*h +: 32]}, {32'd0, port0_data});
            end
        end
    endtask

    task automatic write_buffer();
        logic [31:0] cmd;
        logic [31:0] r;
        logic [31:0] host [2][8];                     // two pages, 8 host words each
        logic [1:0]  pg;
        r = next_rand();
        cmd = {18'd0, 1'b1, r[12:0]};                 // write buffer command
        pg = cmd[11:10];
        for (int p = 0; p < 2; p++) begin
            for (int j = 0; j < 8; j++) begin
                host[p][j] = next_rand();
                @(posedge rst);
                port1_we   <= 1'b1;
                port1_addr <= {pg + 2'(p), 8'(j)};
                port1_data <= host[p][j];
            end
        end
        @(posedge rst);
        port1_we <= 1'b0;
        write_reg(`PS_CMD, cmd);
        wait_request("write buffer");
        grant_and_check("write buffer", cmd);
        repeat (2) @(posedge rst);
        for (int p = 0; p < 2; p++) begin
            if (p == 1) begin
                @(posedge rst);
                rpage_nxt_chn1 <= 1'b1;
                @(posedge rst);
                rpage_nxt_chn1 <= 1'b0;
            end
            for (int i = 0; i < 4; i++) begin
                @(posedge rst);
                buf_rd_chn1 <= 1'b1;
                @(posedge rst);
                buf_rd_chn1 <= 1'b0;
                @(negedge rst);
                check("write buffer", {host[p][2*i+1], host[p][2*i]}, buf_rdata_chn1);
            end
        end
        finish_seq(1'b1);
    endtask

    task automatic status_packet();
        logic [31:0] r;
        logic [31:0] c;
        r = next_rand();
        c = next_rand();
        read_status("status idle", r[5:0], 2'b00);
        write_reg(`PS_CMD, {18'd0, c[13:0]});
        wait_request("status one");
        read_status("status one", r[11:6], 2'b01);    // queued and requesting
        write_reg(`PS_CMD, {18'd0, c[27:14]});
        write_reg(`PS_CMD, {18'd0, c[13:0]});
        read_status("status three", r[17:12], 2'b11); // half full
    endtask

    task automatic channel_reset();
        logic [31:0] r;
        r = next_rand();
        check("channel reset", 64'd1, {63'd0, want_rq0 || want_rq1});
        write_reg(`PS_EN_RST, 32'd2);                 // bit 0 clear
        repeat (2) @(negedge rst);
        expect_no_request("channel reset", 4);
        check("channel reset", 64'd0, {62'd0, need_rq0, need_rq1});
        read_status("channel reset status", r[5:0], 2'b00);
        write_reg(`PS_EN_RST, 32'd3);
        expect_no_request("queue emptied", 6);        // nothing left to start
    endtask

    initial begin
        errors             = 0;
        lcg_state          = 32'h06b74809;
        mclk               <= 1'b0;
        cmd_ad             <= '0;
        cmd_stb            <= 1'b0;
        status_start       <= 1'b0;
        port0_re           <= 1'b0;
        port0_regen        <= 1'b0;
        port0_addr         <= '0;
        port1_we           <= 1'b0;
        port1_addr         <= '0;
        port1_data         <= '0;
        channel_pgm_en0    <= 1'b0;
        seq_done0          <= 1'b0;
        buf_wr_chn0        <= 1'b0;
        buf_wpage_nxt_chn0 <= 1'b0;
        buf_wdata_chn0     <= '0;
        channel_pgm_en1    <= 1'b0;
        seq_done1          <= 1'b0;
        rpage_nxt_chn1     <= 1'b0;
        buf_rd_chn1        <= 1'b0;
        repeat (2) @(posedge rst);
        mclk <= 1'b1;
        @(negedge rst);
        window_and_enable();
        handoff_order();
        read_buffer();
        write_buffer();
        status_packet();
        channel_reset();
        if (errors == 0 && DUT.asserts_i.fail_count == 0) begin   // bound checker too
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mcntrl_ps_pio_asserts.sv
/* concurrent checks on the channel outputs, bound into mcntrl_ps_pio
   port rst is the clock, mclk the active-low reset */
`timescale 1ns/1ns
`default_nettype none

module mcntrl_ps_pio_asserts (
    input logic rst,
    input logic mclk,
    input logic want_rq0,
    input logic need_rq0,
    input logic want_rq1,
    input logic need_rq1,
    input logic seq_set0,
    input logic status_rq
);
    int unsigned fail_count = 0;   // assertion failures so far

    one_channel: assert property (@(posedge rst) disable iff (!mclk)
        !(want_rq0 && want_rq1))                     // one command at a time
        else begin
            fail_count++;
            $error("both channels request the arbiter at once");
        end

    need0_with_want: assert property (@(posedge rst) disable iff (!mclk)
        need_rq0 |-> want_rq0)
        else begin
            fail_count++;
            $error("need_rq0 without want_rq0");
        end

    need1_with_want: assert property (@(posedge rst) disable iff (!mclk)
        need_rq1 |-> want_rq1)
        else begin
            fail_count++;
            $error("need_rq1 without want_rq1");
        end

    seq_set_pulse: assert property (@(posedge rst) disable iff (!mclk)
        seq_set0 |=> !seq_set0)                      // single-cycle handoff
        else begin
            fail_count++;
            $error("seq_set0 held longer than one cycle");
        end

    no_status_in_reset: assert property (@(posedge rst)
        !mclk |-> !status_rq)
        else begin
            fail_count++;
            $error("status_rq high during reset");
        end

endmodule

bind mcntrl_ps_pio mcntrl_ps_pio_asserts asserts_i (
    .rst(rst), .mclk(mclk),
    .want_rq0(want_rq0), .need_rq0(need_rq0),
    .want_rq1(want_rq1), .need_rq1(need_rq1),
    .seq_set0(seq_set0), .status_rq(status_rq)
);

`default_nettype wire

//--- rtl/mcntrl_ps_pio.sv
/* software-programmed DDR channel: byte-serial register writes, command queue,
   arbiter requests, read buffer chn0 and write buffer chn1 on the same clock */
`timescale 1ns/1ns
`default_nettype none
`include "ps_pio_consts.svh"

module mcntrl_ps_pio
    import ps_pio_cmd_pkg::*;
    import ps_pio_buf_pkg::*;
(
    input  logic       rst,
    input  logic       mclk,
    input  logic [7:0] cmd_ad,          // AL AH D0 D1 D2 D3
    input  logic       cmd_stb,         // with AL
    output logic [7:0] status_ad,
    output logic       status_rq,
    input  logic       status_start,
    input  logic       port0_re,        // host read of read buffer
    input  logic       port0_regen,
    input  host_addr_t port0_addr,
    output host_word_t port0_data,
    input  logic       port1_we,        // host write of write buffer
    input  host_addr_t port1_addr,
    input  host_word_t port1_data,
    output logic       want_rq0,
    output logic       need_rq0,
    input  logic       channel_pgm_en0,
    output logic [9:0] seq_data0,       // shared by both channels
    output logic       seq_set0,
    input  logic       seq_done0,
    input  logic       buf_wr_chn0,
    input  logic       buf_wpage_nxt_chn0,
    input  mem_word_t  buf_wdata_chn0,
    output logic       want_rq1,
    output logic       need_rq1,
    input  logic       channel_pgm_en1,
    input  logic       seq_done1,
    input  logic       rpage_nxt_chn1,
    input  logic       buf_rd_chn1,
    output mem_word_t  buf_rdata_chn1
);
    cmd_subaddr_t cmd_addr;
    logic [31:0]  cmd_data;
    logic         cmd_we;
    logic         push;
    logic         pop;
    logic         status_we;
    logic         chn_clear;
    pio_cmd_t     head;
    logic         nempty;
    logic         half_full;
    logic         busy;
    logic [1:0]   status_data;
    logic         page_set0;
    logic         page_set1;
    buf_page_t    page;

    assign status_data = {half_full, nempty | busy};

    cmd_deser cmd_deser_i (
        .rst(rst), .mclk(mclk), .ad(cmd_ad), .stb(cmd_stb),
        .addr(cmd_addr), .data(cmd_data), .we(cmd_we)
    );

    cmd_fifo cmd_fifo_i (
        .rst(rst), .mclk(mclk), .sync_rst(chn_clear), .we(push), .re(pop),
        .data_in(pio_cmd_t'(cmd_data[$bits(pio_cmd_t)-1:0])),
        .data_out(head), .nempty(nempty), .half_full(half_full)
    );

    status_generate status_generate_i (
        .rst(rst), .mclk(mclk), .we(status_we), .wd(cmd_data[7:0]),
        .status(status_data), .ad(status_ad), .rq(status_rq), .start(status_start)
    );

    ps_pio_control control_i (
        .rst(rst), .mclk(mclk), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
        .cmd_we(cmd_we), .push(push), .status_we(status_we), .chn_clear(chn_clear),
        .head(head), .nempty(nempty), .pop(pop),
        .channel_pgm_en0(channel_pgm_en0), .channel_pgm_en1(channel_pgm_en1),
        .seq_done0(seq_done0), .seq_done1(seq_done1),
        .want_rq0(want_rq0), .need_rq0(need_rq0),
        .want_rq1(want_rq1), .need_rq1(need_rq1),
        .seq_data(seq_data0), .seq_set(seq_set0),
        .page_set0(page_set0), .page_set1(page_set1), .page(page), .busy(busy)
    );

    // read buffer, memory writes and host reads
    page_buffer chn0_buf (
        .rst(rst), .mclk(mclk),
        .host_addr(port0_addr), .host_re(port0_re), .host_regen(port0_regen),
        .host_we(1'b0), .host_wdata('0), .host_rdata(port0_data),
        .page_set(page_set0), .page_in(page), .page_next(buf_wpage_nxt_chn0),
        .mem_we(buf_wr_chn0), .mem_wdata(buf_wdata_chn0),
        .mem_rd(1'b0), .mem_rdata()
    );

    // write buffer, host writes and memory reads
    page_buffer chn1_buf (
        .rst(rst), .mclk(mclk),
        .host_addr(port1_addr), .host_re(1'b0), .host_regen(1'b0),
        .host_we(port1_we), .host_wdata(port1_data), .host_rdata(),
        .page_set(page_set1), .page_in(page), .page_next(rpage_nxt_chn1),
        .mem_we(1'b0), .mem_wdata('0),
        .mem_rd(buf_rd_chn1), .mem_rdata(buf_rdata_chn1)
    );

endmodule

`default_nettype wire

//--- rtl/page_buffer.sv
/* 4-page buffer, host side 1K x 32, memory side 512 x 64
   host word 2i is the low half of memory word i; both sides share one clock */
`timescale 1ns/1ns
`default_nettype none

module page_buffer
    import ps_pio_buf_pkg::*;
(
    input  logic       rst,
    input  logic       mclk,
    input  host_addr_t host_addr,
    input  logic       host_re,
    input  logic       host_regen,
    input  logic       host_we,
    input  host_word_t host_wdata,
    output host_word_t host_rdata,
    input  logic       page_set,
    input  buf_page_t  page_in,
    input  logic       page_next,
    input  logic       mem_we,
    input  mem_word_t  mem_wdata,
    input  logic       mem_rd,
    output mem_word_t  mem_rdata
);
    mem_word_t  ram [512];
    buf_page_t  page;       // memory-side page
    mem_idx_t   idx;        // memory-side word index
    host_word_t host_q;     // first host read stage
    logic [8:0] mem_addr;
    logic [8:0] host_row;   // host address as memory word

    assign mem_addr = {page, idx};
    assign host_row = host_addr[9:1];

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            page <= '0;
            idx  <= '0;
        end else if (page_set) begin
            page <= page_in;
            idx  <= '0;
        end else if (page_next) begin
            page <= page + 2'd1;
            idx  <= '0;
        end else if (mem_we || mem_rd) begin
            idx <= idx + 7'd1;     // post-increment after each access
        end
    end

    always_ff @(posedge rst) begin
        if (mem_we) ram[mem_addr] <= mem_wdata;
        if (host_we) begin
            if (host_addr[0]) ram[host_row][63:32] <= host_wdata;
            else              ram[host_row][31:0]  <= host_wdata;
        end
        if (host_re)
            host_q <= host_addr[0] ? ram[host_row][63:32] : ram[host_row][31:0];
        if (host_regen) host_rdata <= host_q;   // valid two edges after re
        if (mem_rd) mem_rdata <= ram[mem_addr];
    end

endmodule

`default_nettype wire

//--- rtl/ps_pio_control.sv
/* channel control: sub-address decode, enable register, arbiter requests,
   sequencer handoff and buffer page set; a grant counts only while requested */
`timescale 1ns/1ns
`default_nettype none
`include "ps_pio_consts.svh"

module ps_pio_control
    import ps_pio_cmd_pkg::*;
    import ps_pio_buf_pkg::*;
(
    input  logic         rst,
    input  logic         mclk,
    input  cmd_subaddr_t cmd_addr,
    input  logic [31:0]  cmd_data,
    input  logic         cmd_we,
    output logic         push,
    output logic         status_we,
    output logic         chn_clear,
    input  pio_cmd_t     head,
    input  logic         nempty,
    output logic         pop,
    input  logic         channel_pgm_en0,
    input  logic         channel_pgm_en1,
    input  logic         seq_done0,
    input  logic         seq_done1,
    output logic         want_rq0,
    output logic         need_rq0,
    output logic         want_rq1,
    output logic         need_rq1,
    output logic [9:0]   seq_data,
    output logic         seq_set,
    output logic         page_set0,
    output logic         page_set1,
    output buf_page_t    page,
    output logic         busy
);
    logic [1:0] en_reg;      // bit0 out of reset, bit1 requests enabled
    logic       mem_run;     // granted, sequencer running
    logic       run_chn;     // channel of running command
    logic       page_set_d;
    logic       grant;
    logic       start;
    logic       set_en_rst;

    assign set_en_rst = cmd_we && (cmd_addr == `PS_EN_RST);
    assign push       = cmd_we && (cmd_addr == `PS_CMD);
    assign status_we  = cmd_we && (cmd_addr == `PS_STATUS_CNTRL);
    assign chn_clear  = !en_reg[0];
    assign busy       = want_rq0 || need_rq0 || want_rq1 || need_rq1 || mem_run;
    assign start      = en_reg[1] && !busy && nempty;
    assign grant      = (channel_pgm_en0 && want_rq0) || (channel_pgm_en1 && want_rq1);
    assign seq_data   = head.seq_addr;       // head still in queue at seq_set
    assign pop        = seq_set;
    assign page_set0  = page_set_d && !run_chn;
    assign page_set1  = page_set_d && run_chn;

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            en_reg     <= '0;
            want_rq0   <= 1'b0;
            need_rq0   <= 1'b0;
            want_rq1   <= 1'b0;
            need_rq1   <= 1'b0;
            mem_run    <= 1'b0;
            seq_set    <= 1'b0;
            page_set_d <= 1'b0;
            run_chn    <= 1'b0;
            page       <= '0;
        end else begin
            if (set_en_rst) en_reg <= cmd_data[1:0];
            if (chn_clear || grant) begin    // drop requests once granted
                want_rq0 <= 1'b0;
                need_rq0 <= 1'b0;
                want_rq1 <= 1'b0;
                need_rq1 <= 1'b0;
            end else if (start) begin
                want_rq0 <= !head.chn;
                need_rq0 <= !head.chn && head.need;
                want_rq1 <= head.chn;
                need_rq1 <= head.chn && head.need;
            end
            if (chn_clear || seq_done0 || seq_done1)
                mem_run <= 1'b0;
            else if (grant)
                mem_run <= 1'b1;
            seq_set    <= grant && !chn_clear;
            page_set_d <= seq_set && !chn_clear;   // page one cycle after seq_set
            if (seq_set) begin
                run_chn <= head.chn;
                page    <= head.page;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/cmd_fifo.sv
/* command queue, head always visible on data_out
   writes into a full queue are dropped, DEPTH must be a power of two */
`timescale 1ns/1ns
`default_nettype none
`include "ps_pio_consts.svh"

module cmd_fifo
    import ps_pio_cmd_pkg::*;
#(
    parameter int DEPTH = `CMD_FIFO_DEPTH
) (
    input  logic     rst,
    input  logic     mclk,
    input  logic     sync_rst,
    input  logic     we,
    input  logic     re,
    input  pio_cmd_t data_in,
    output pio_cmd_t data_out,
    output logic     nempty,
    output logic     half_full
);
    localparam int AW = $clog2(DEPTH);

    pio_cmd_t        q [DEPTH];
    logic [AW-1:0]   wptr;
    logic [AW-1:0]   rptr;
    logic [AW:0]     count;    // entries held
    logic            wr_ok;
    logic            rd_ok;

    assign wr_ok     = we && (count != (AW+1)'(DEPTH));
    assign rd_ok     = re && nempty;
    assign nempty    = (count != '0);
    assign half_full = (count >= (AW+1)'(DEPTH / 2));
    assign data_out  = q[rptr];

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (sync_rst) begin   // channel reset empties queue
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_ok) wptr <= wptr + AW'(1);
            if (rd_ok) rptr <= rptr + AW'(1);
            count <= count + (AW+1)'(wr_ok) - (AW+1)'(rd_ok);
        end
    end

    always_ff @(posedge rst) begin
        if (wr_ok) q[wptr] <= data_in;
    end

endmodule

`default_nettype wire

//--- rtl/status_generate.sv
/* status packet sender, address byte held with rq until start,
   then one byte of sequence number and payload; payload sampled at start */
`timescale 1ns/1ns
`default_nettype none
`include "ps_pio_consts.svh"

module status_generate
    import ps_pio_cmd_pkg::*;
(
    input  logic       rst,
    input  logic       mclk,
    input  logic       we,
    input  logic [7:0] wd,
    input  logic [1:0] status,
    output logic [7:0] ad,
    output logic       rq,
    input  logic       start
);
    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

    status_mode_t mode;
    logic [5:0]   seq_num;
    logic [1:0]   sent;     // payload of last packet
    logic         pend;     // packet asked by host write
    logic         trig;
    state_t       state;

    assign trig = pend || ((mode == ST_AUTO) && (status != sent));
    assign rq   = (state == S_ADDR);

    always_comb begin
        case (state)
            S_ADDR:  ad = `PS_STATUS_REG_ADDR;
            S_DATA:  ad = {seq_num, sent};
            default: ad = 8'h00;
        endcase
    end

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            mode    <= ST_OFF;
            seq_num <= '0;
            sent    <= '0;
            pend    <= 1'b0;
            state   <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (trig) state <= S_ADDR;
                S_ADDR: if (start) begin
                    state <= S_DATA;
                    sent  <= status;                         // what goes out next cycle
                    if (mode == ST_SINGLE) mode <= ST_OFF;   // one shot
                end
                default: state <= S_IDLE;                    // data byte done
            endcase
            if (we) begin                                    // host write wins
                mode    <= status_mode_t'(wd[7:6]);
                seq_num <= wd[5:0];
                pend    <= (wd[7:6] != 2'b00);
            end else if ((state == S_IDLE) && trig) begin
                pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/cmd_deser.sv
/* byte-serial command receiver, stb comes with the first byte
   a new stb restarts assembly; addr and data hold until the next command */
`timescale 1ns/1ns
`default_nettype none
`include "ps_pio_consts.svh"

module cmd_deser
    import ps_pio_cmd_pkg::*;
(
    input  logic         rst,
    input  logic         mclk,
    input  logic [7:0]   ad,
    input  logic         stb,
    output cmd_subaddr_t addr,
    output logic [31:0]  data,
    output logic         we
);
    localparam int LAST = `CMD_NUM_BYTES - 1;

    logic [2:0]  cnt;      // index of next byte, 0 when idle
    logic [15:0] a16;      // full command address
    logic        match;

    assign match = ((a16 & `PS_MASK) == `PS_ADDR); // AH already in place at D3
    assign addr  = a16[4:0];

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            cnt <= '0;
            we  <= 1'b0;
        end else begin
            we <= (cnt == 3'(LAST)) && match; // one cycle after D3
            if (stb)
                cnt <= 3'd1;
            else if (cnt == 3'(LAST))
                cnt <= '0;
            else if (cnt != '0)
                cnt <= cnt + 3'd1;
        end
    end

    // address and data shift registers
    always_ff @(posedge rst) begin
        if (stb)
            a16[7:0] <= ad;             // AL
        else if (cnt == 3'd1)
            a16[15:8] <= ad;            // AH
        else if (cnt != '0)
            data <= {ad, data[31:8]};   // D0 ends up lowest
    end

endmodule

`default_nettype wire

//--- rtl/ps_pio_buf_pkg.sv
/* page buffer types, host side 1K x 32, memory side 512 x 64 */
`default_nettype none

package ps_pio_buf_pkg;

    typedef logic [1:0]  buf_page_t;   // one of four pages
    typedef logic [9:0]  host_addr_t;  // page in top 2 bits
    typedef logic [31:0] host_word_t;
    typedef logic [63:0] mem_word_t;
    typedef logic [6:0]  mem_idx_t;    // word within a page

endpackage

`default_nettype wire

//--- rtl/ps_pio_cmd_pkg.sv
/* channel command and status types
   pio_cmd_t matches bits 13:0 of a command push */
`default_nettype none

package ps_pio_cmd_pkg;

    // command word pushed into the queue
    typedef struct packed {
        logic       chn;       // 0 read buffer, 1 write buffer
        logic       need;      // urgent request
        logic [1:0] page;      // buffer page
        logic [9:0] seq_addr;  // sequencer program address
    } pio_cmd_t;

    typedef logic [4:0] cmd_subaddr_t; // address inside window

    // status packet modes, value 2 is reserved
    typedef enum logic [1:0] {
        ST_OFF    = 2'd0,
        ST_SINGLE = 2'd1,
        ST_AUTO   = 2'd3
    } status_mode_t;

endpackage

`default_nettype wire

//--- rtl/ps_pio_consts.svh
/* register window, sub-addresses and sizes of the ps pio channel
   only address bits 9:5 are compared, so the window repeats above 0x3ff
   queue depth must stay a power of two */
`ifndef PS_PIO_CONSTS_SVH
`define PS_PIO_CONSTS_SVH

`define PS_ADDR            16'h100 // window base
`define PS_MASK            16'h3e0 // bits compared against base

// sub-addresses inside the window
`define PS_EN_RST          5'd0    // enable/reset register
`define PS_CMD             5'd1    // command push
`define PS_STATUS_CNTRL    5'd2    // status mode and sequence

`define PS_STATUS_REG_ADDR 8'h02   // first byte of a status packet

`define CMD_FIFO_DEPTH     4       // queue entries
`define CMD_NUM_BYTES      6       // AL AH D0 D1 D2 D3

`endif
